// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -j 0 -Wno-fatal --timescale 1ns/1ps \
		--top-module coreTb -f flist.f --Mdir obj_dir -o coreTbSim
	./obj_dir/coreTbSim

clean:
	rm -rf obj_dir

// File: flist.f
+incdir+include
hw/mipsPkg.sv
hw/regFile.sv
hw/alu.sv
hw/fetchStage.sv
hw/controlDecode.sv
hw/executeStage.sv
hw/memWriteback.sv
hw/mipsCore.sv
verif/coreTb.sv

// File: hw/alu.sv
`timescale 1ns/1ps

module alu import mipsPkg::*; (
   input  logic [31:0] a,
   input  logic [31:0] b,
   input  logic [4:0]  shamt,
   input  aluOpE       op,
   output logic [31:0] result
);

   always_comb begin
      case (op)
         ALU_ADD: result = a + b;
         ALU_SUB: result = a - b;
         ALU_AND: result = a & b;
         ALU_OR:  result = a | b;
         ALU_XOR: result = a ^ b;
         ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};
         ALU_SLL: result = b << shamt;
         ALU_LUI: result = {b[15:0], 16'h0000};   // immediate to upper half
         default: result = a + b;
      endcase
   end

endmodule

// File: hw/controlDecode.sv
`timescale 1ns/1ps

module controlDecode import mipsPkg::*; (
   input  instrT      instr,
   input  logic [4:0] mwWriteAddr,
   input  logic       mwRegWrite,
   output ctrlT       ctrl
);

   logic fwdRs;
   logic fwdRt;

   // previous instruction writes a source register
   assign fwdRs = mwRegWrite && (mwWriteAddr != 5'd0) && (mwWriteAddr == instr.rType.rs);
   assign fwdRt = mwRegWrite && (mwWriteAddr != 5'd0) && (mwWriteAddr == instr.rType.rt);

   always_comb begin
      ctrl = '0;
      case (instr.rType.opcode)
         OP_RTYPE: begin
            ctrl.regDst   = DST_RD;
            ctrl.regWrite = 1'b1;
            case (instr.rType.funct)
               F_ADDU: ctrl.aluOp = ALU_ADD;
               F_SUBU: ctrl.aluOp = ALU_SUB;
               F_AND:  ctrl.aluOp = ALU_AND;
               F_OR:   ctrl.aluOp = ALU_OR;
               F_XOR:  ctrl.aluOp = ALU_XOR;
               F_SLT:  ctrl.aluOp = ALU_SLT;
               F_SLL:  ctrl.aluOp = ALU_SLL;   // shifts rt
               F_JR: begin
                  ctrl.regWrite = 1'b0;
                  ctrl.jumpKind = JMP_REG;
               end
               default: ctrl.regWrite = 1'b0;
            endcase
         end
         OP_ADDIU, OP_ORI, OP_LUI: begin
            ctrl.srcBSel  = SRCB_IMM;
            ctrl.regWrite = 1'b1;
            case (instr.iType.opcode)
               OP_ORI:  ctrl.aluOp = ALU_OR;
               OP_LUI:  ctrl.aluOp = ALU_LUI;
               default: ctrl.aluOp = ALU_ADD;
            endcase
         end
         OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU: begin
            ctrl.srcBSel    = SRCB_IMM;
            ctrl.regWrite   = 1'b1;
            ctrl.wbSel      = WB_LOAD;
            ctrl.serialRead = 1'b1;
            case (instr.iType.opcode)
               OP_LH:   ctrl.loadKind = LD_HALF;
               OP_LHU:  ctrl.loadKind = LD_HALFU;
               OP_LB:   ctrl.loadKind = LD_BYTE;
               OP_LBU:  ctrl.loadKind = LD_BYTEU;
               default: ctrl.loadKind = LD_WORD;
            endcase
         end
         OP_SW, OP_SB: begin
            ctrl.srcBSel     = SRCB_IMM;
            ctrl.memWrite    = 1'b1;
            ctrl.serialWrite = 1'b1;
            ctrl.byteEnable  = (instr.iType.opcode == OP_SW) ? 4'b1111 : 4'b1000;
         end
         OP_BEQ, OP_BNE: begin
            ctrl.isBranch      = 1'b1;
            ctrl.branchOnEqual = (instr.iType.opcode == OP_BEQ);
         end
         OP_J: ctrl.jumpKind = JMP_TARGET;
         OP_JAL: begin
            ctrl.jumpKind = JMP_TARGET;
            ctrl.srcASel  = SRCA_PC;
            ctrl.srcBSel  = SRCB_EIGHT;   // link = pc + 8
            ctrl.regDst   = DST_RA;
            ctrl.regWrite = 1'b1;
         end
         default: ctrl = '0;
      endcase

      // register operands switch to the writeback value on a match
      if (ctrl.srcASel == SRCA_REG && fwdRs) begin
         ctrl.srcASel = SRCA_FWD;
      end
      if (ctrl.srcBSel == SRCB_REG && fwdRt) begin
         ctrl.srcBSel = SRCB_FWD;
      end
      ctrl.storeFwd = fwdRt;
   end

endmodule

// File: hw/executeStage.sv
`timescale 1ns/1ps

module executeStage import mipsPkg::*; (
   input  logic        CLK,
   input  logic        arstN,
   input  logic        stall,
   input  instrT       instr,
   input  logic [31:0] instrPc,
   input  ctrlT        ctrl,
   input  logic [31:0] wbData,
   input  logic [4:0]  wbAddr,
   input  logic        wbEnable,
   output logic        taken,
   output logic [31:0] target,
   output exMwT        exMw
);

   logic [31:0] regA;
   logic [31:0] regB;
   logic [31:0] opA;
   logic [31:0] opB;
   logic [31:0] immExt;
   logic [31:0] aluOut;
   logic [31:0] pcPlus4;
   logic [31:0] rtVal;
   logic [4:0]  writeAddr;
   logic        isSerial;
   exMwT        exMwNext;

   regFile regFile_inst (
      .CLK(CLK), .arstN(arstN),
      .readAddrA(instr.rType.rs), .readAddrB(instr.rType.rt),
      .writeAddr(wbAddr), .writeData(wbData), .writeEnable(wbEnable),
      .readDataA(regA), .readDataB(regB)
   );

   alu alu_inst (
      .a(opA), .b(opB), .shamt(instr.rType.shamt), .op(ctrl.aluOp), .result(aluOut)
   );

   // ori zero-extends, everything else sign-extends
   assign immExt = (instr.iType.opcode == OP_ORI) ? {16'h0000, instr.iType.imm}
                                                  : {{16{instr.iType.imm[15]}}, instr.iType.imm};
   assign pcPlus4 = instrPc + 32'd4;
   assign rtVal = ctrl.storeFwd ? wbData : regB;
   assign isSerial = (aluOut[31:16] == SERIAL_BASE[31:16]);

   always_comb begin
      case (ctrl.srcASel)
         SRCA_PC:  opA = instrPc;
         SRCA_FWD: opA = wbData;
         default:  opA = regA;
      endcase
      case (ctrl.srcBSel)
         SRCB_EIGHT: opB = 32'd8;
         SRCB_FWD:   opB = wbData;
         SRCB_IMM:   opB = immExt;
         default:    opB = regB;
      endcase
      case (ctrl.regDst)
         DST_RD:  writeAddr = instr.rType.rd;
         DST_RA:  writeAddr = 5'd31;
         default: writeAddr = instr.rType.rt;
      endcase
   end

   // branch compare uses the muxed register operands
   always_comb begin
      taken = (ctrl.isBranch && ((opA == opB) == ctrl.branchOnEqual))
              || (ctrl.jumpKind != JMP_NONE);
      case (ctrl.jumpKind)
         JMP_TARGET: target = {pcPlus4[31:28], instr.jType.target, 2'b00};
         JMP_REG:    target = opA;
         default:    target = pcPlus4 + {immExt[29:0], 2'b00};
      endcase
   end

   always_comb begin
      exMwNext.aluOut     = aluOut;
      exMwNext.storeData  = (ctrl.byteEnable == 4'b1111) ? rtVal : {4{rtVal[7:0]}};
      exMwNext.writeAddr  = writeAddr;
      exMwNext.regWrite   = ctrl.regWrite;
      exMwNext.byteEnable = (ctrl.memWrite && !isSerial) ? ctrl.byteEnable >> aluOut[1:0]
                                                         : 4'b0000;
      exMwNext.wbSel      = (isSerial && ctrl.wbSel == WB_LOAD) ? WB_SERIAL : ctrl.wbSel;
      exMwNext.loadKind   = ctrl.loadKind;
      exMwNext.serialWrite = ctrl.serialWrite && isSerial && (aluOut[3:0] == SERIAL_TX);
      exMwNext.serialRead  = ctrl.serialRead && isSerial && (aluOut[3:0] == SERIAL_RX);
   end

   always_ff @(posedge CLK or negedge arstN) begin
      if (!arstN) begin
         exMw <= '0;
      end else if (!stall) begin
         exMw <= exMwNext;
      end
   end

endmodule

// File: hw/fetchStage.sv
`timescale 1ns/1ps

module fetchStage import mipsPkg::*; (
   input  logic               CLK,
   input  logic               arstN,
   input  logic               stall,
   input  logic               taken,
   input  logic [31:0]        target,
   input  logic               bootWe,
   input  logic [IMEM_AW-1:0] bootAddr,
   input  logic [31:0]        bootData,
   output instrT              instr,
   output logic [31:0]        instrPc
);

   logic [31:0] imem [IMEM_WORDS];
   logic [31:0] pc;

   // boot port, only used while the core sits in reset
   always_ff @(posedge CLK) begin
      if (bootWe) begin
         imem[bootAddr] <= bootData;
      end
   end

   always_ff @(posedge CLK or negedge arstN) begin
      if (!arstN) begin
         pc      <= RESET_PC;
         instr   <= NOP_WORD;
         instrPc <= RESET_PC;
      end else if (!stall) begin
         pc      <= taken ? target : pc + 32'd4;   // delay slot already in flight
         instr   <= imem[pc[IMEM_AW+1:2]];
         instrPc <= pc;
      end
   end

endmodule

// File: hw/memWriteback.sv
`timescale 1ns/1ps

module memWriteback import mipsPkg::*; (
   input  logic        CLK,
   input  logic        arstN,
   input  exMwT        exMw,
   input  logic        txReady,
   input  logic        rxValid,
   input  logic [7:0]  rxData,
   output logic [7:0]  txData,
   output logic        txValid,
   output logic        rxReady,
   output logic        stall,
   output logic [31:0] wbData,
   output logic [4:0]  wbAddr,
   output logic        wbEnable
);

   logic [31:0]        dmem [DMEM_WORDS];
   logic [DMEM_AW-1:0] wordAddr;
   logic [1:0]         offset;
   logic [31:0]        readWord;
   logic [31:0]        loadData;
   logic [31:0]        serialData;
   logic [7:0]         selByte;
   logic [15:0]        selHalf;

   // one-entry store buffer, commits the cycle after the memory stage
   logic               pendValid;
   logic [DMEM_AW-1:0] pendAddr;
   logic [31:0]        pendData;
   logic [3:0]         pendBe;
   logic               pendHit;

   assign wordAddr = exMw.aluOut[DMEM_AW+1:2];
   assign offset = exMw.aluOut[1:0];
   assign pendHit = pendValid && (pendAddr == wordAddr);

   always_ff @(posedge CLK or negedge arstN) begin
      if (!arstN) begin
         pendValid <= 1'b0;
      end else if (!stall) begin
         pendValid <= |exMw.byteEnable;
      end
   end

   always_ff @(posedge CLK) begin
      if (!stall) begin
         pendAddr <= wordAddr;
         pendData <= exMw.storeData;
         pendBe   <= exMw.byteEnable;
         for (int i = 0; i < 4; i++) begin
            if (pendValid && pendBe[i]) begin
               dmem[pendAddr][8*i +: 8] <= pendData[8*i +: 8];
            end
         end
      end
   end

   // big-endian lanes, byte 0 is bits 31:24
   always_comb begin
      readWord = dmem[wordAddr];
      for (int i = 0; i < 4; i++) begin
         if (pendHit && pendBe[i]) begin
            readWord[8*i +: 8] = pendData[8*i +: 8];   // bypass the pending store
         end
      end
      selByte = readWord[8 * (3 - offset) +: 8];
      selHalf = offset[1] ? readWord[15:0] : readWord[31:16];
      case (exMw.loadKind)
         LD_HALF:  loadData = {{16{selHalf[15]}}, selHalf};
         LD_HALFU: loadData = {16'h0000, selHalf};
         LD_BYTE:  loadData = {{24{selByte[7]}}, selByte};
         LD_BYTEU: loadData = {24'h000000, selByte};
         default:  loadData = readWord;
      endcase
   end

   always_comb begin
      case (exMw.aluOut[3:0])
         SERIAL_STATUS: serialData = {30'd0, rxValid, txReady};
         SERIAL_RX:     serialData = {24'd0, rxData};
         default:       serialData = '0;
      endcase
      case (exMw.wbSel)
         WB_LOAD:   wbData = loadData;
         WB_SERIAL: wbData = serialData;
         default:   wbData = exMw.aluOut;
      endcase
   end

   assign stall = exMw.serialWrite && !txReady;   // hold until partner accepts
   assign txValid = exMw.serialWrite && txReady;
   assign txData = exMw.storeData[7:0];
   assign rxReady = exMw.serialRead;
   assign wbAddr = exMw.writeAddr;
   assign wbEnable = exMw.regWrite && !stall;

endmodule

// File: hw/mipsCore.sv
`timescale 1ns/1ps

module mipsCore import mipsPkg::*; (
   input  logic               CLK,
   input  logic               arstN,
   input  logic               bootWe,
   input  logic [IMEM_AW-1:0] bootAddr,
   input  logic [31:0]        bootData,
   output logic [7:0]         txData,
   output logic               txValid,
   input  logic               txReady,
   input  logic [7:0]         rxData,
   input  logic               rxValid,
   output logic               rxReady
);

   instrT       instr;
   logic [31:0] instrPc;
   ctrlT        ctrl;
   logic        taken;
   logic [31:0] target;
   exMwT        exMw;
   logic        stall;
   logic [31:0] wbData;
   logic [4:0]  wbAddr;
   logic        wbEnable;

   fetchStage fetchStage_inst (
      .CLK(CLK), .arstN(arstN), .stall(stall), .taken(taken), .target(target),
      .bootWe(bootWe), .bootAddr(bootAddr), .bootData(bootData),
      .instr(instr), .instrPc(instrPc)
   );

   controlDecode controlDecode_inst (
      .instr(instr), .mwWriteAddr(wbAddr), .mwRegWrite(wbEnable), .ctrl(ctrl)
   );

   executeStage executeStage_inst (
      .CLK(CLK), .arstN(arstN), .stall(stall),
      .instr(instr), .instrPc(instrPc), .ctrl(ctrl),
      .wbData(wbData), .wbAddr(wbAddr), .wbEnable(wbEnable),
      .taken(taken), .target(target), .exMw(exMw)
   );

   memWriteback memWriteback_inst (
      .CLK(CLK), .arstN(arstN), .exMw(exMw),
      .txReady(txReady), .rxValid(rxValid), .rxData(rxData),
      .txData(txData), .txValid(txValid), .rxReady(rxReady), .stall(stall),
      .wbData(wbData), .wbAddr(wbAddr), .wbEnable(wbEnable)
   );

endmodule

// File: hw/mipsPkg.sv
package mipsPkg;

   localparam int IMEM_WORDS = 1024;
   localparam int DMEM_WORDS = 1024;
   localparam int IMEM_AW = $clog2(IMEM_WORDS);   // word address bits
   localparam int DMEM_AW = $clog2(DMEM_WORDS);

   localparam logic [31:0] SERIAL_BASE = 32'h8000_0000;
   localparam logic [3:0] SERIAL_STATUS = 4'h0;   // bit 0 txReady, bit 1 rxValid
   localparam logic [3:0] SERIAL_RX = 4'h4;
   localparam logic [3:0] SERIAL_TX = 4'h8;

   localparam logic [31:0] RESET_PC = 32'h0000_0000;
   localparam logic [31:0] NOP_WORD = 32'h0000_0000;   // sll $0, $0, 0

   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00, OP_J = 6'h02, OP_JAL = 6'h03, OP_BEQ = 6'h04, OP_BNE = 6'h05,
      OP_ADDIU = 6'h09, OP_ORI = 6'h0d, OP_LUI = 6'h0f,
      OP_LB = 6'h20, OP_LH = 6'h21, OP_LW = 6'h23, OP_LBU = 6'h24, OP_LHU = 6'h25,
      OP_SB = 6'h28, OP_SW = 6'h2b
   } opcodeE;

   typedef enum logic [5:0] {
      F_SLL = 6'h00, F_JR = 6'h08, F_ADDU = 6'h21, F_SUBU = 6'h23,
      F_AND = 6'h24, F_OR = 6'h25, F_XOR = 6'h26, F_SLT = 6'h2a
   } functE;

   typedef struct packed {
      opcodeE     opcode;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      functE      funct;
   } rTypeT;

   typedef struct packed {
      opcodeE      opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
   } iTypeT;

   typedef struct packed {
      opcodeE      opcode;
      logic [25:0] target;   // word index within the 256 MB region
   } jTypeT;

   // one instruction word, three field layouts
   typedef union packed {
      rTypeT rType;
      iTypeT iType;
      jTypeT jType;
   } instrT;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_LUI
   } aluOpE;

   typedef enum logic [1:0] {SRCA_REG, SRCA_PC, SRCA_FWD} srcASelE;
   typedef enum logic [1:0] {SRCB_REG, SRCB_EIGHT, SRCB_FWD, SRCB_IMM} srcBSelE;
   typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_SERIAL} wbSelE;
   typedef enum logic [2:0] {LD_WORD, LD_HALF, LD_HALFU, LD_BYTE, LD_BYTEU} loadKindE;
   typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA} regDstE;
   typedef enum logic [1:0] {JMP_NONE, JMP_TARGET, JMP_REG} jumpKindE;

   typedef struct packed {
      aluOpE      aluOp;
      srcASelE    srcASel;
      srcBSelE    srcBSel;
      regDstE     regDst;
      logic       regWrite;
      logic       memWrite;
      logic [3:0] byteEnable;   // lanes for offset 0, msb is byte 0
      loadKindE   loadKind;
      wbSelE      wbSel;
      logic       isBranch;
      logic       branchOnEqual;
      jumpKindE   jumpKind;
      logic       serialWrite;   // store intent, address checked in execute
      logic       serialRead;    // load intent
      logic       storeFwd;      // store data comes from the forward path
   } ctrlT;

   typedef struct packed {
      logic [31:0] aluOut;
      logic [31:0] storeData;
      logic [4:0]  writeAddr;
      logic        regWrite;
      logic [3:0]  byteEnable;   // final data memory lanes
      wbSelE       wbSel;
      loadKindE    loadKind;
      logic        serialWrite;
      logic        serialRead;
   } exMwT;

endpackage

// File: hw/regFile.sv
`timescale 1ns/1ps

module regFile (
   input  logic        CLK,
   input  logic        arstN,
   input  logic [4:0]  readAddrA,
   input  logic [4:0]  readAddrB,
   input  logic [4:0]  writeAddr,
   input  logic [31:0] writeData,
   input  logic        writeEnable,
   output logic [31:0] readDataA,
   output logic [31:0] readDataB
);

   logic [31:0] regs [1:31];   // $0 has no storage

   always_ff @(posedge CLK or negedge arstN) begin
      if (!arstN) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEnable && writeAddr != 5'd0) begin
         regs[writeAddr] <= writeData;
      end
   end

   assign readDataA = (readAddrA == 5'd0) ? '0 : regs[readAddrA];
   assign readDataB = (readAddrB == 5'd0) ? '0 : regs[readAddrB];

endmodule

// File: include/tbAsm.svh
`ifndef TB_ASM_SVH
`define TB_ASM_SVH

// instruction encoders, included inside a module that imports mipsPkg

function automatic logic [31:0] asmR(input functE funct, input logic [4:0] rd, rs, rt);
   return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
endfunction

function automatic logic [31:0] asmSll(input logic [4:0] rd, rt, shamt);
   return {OP_RTYPE, 5'd0, rt, rd, shamt, F_SLL};
endfunction

function automatic logic [31:0] asmJr(input logic [4:0] rs);
   return {OP_RTYPE, rs, 5'd0, 5'd0, 5'd0, F_JR};
endfunction

// addiu, ori, lui and all loads and stores, rs is the base
function automatic logic [31:0] asmI(input opcodeE op, input logic [4:0] rt, rs,
                                     input logic [15:0] imm);
   return {op, rs, rt, imm};
endfunction

// offset counts words from the delay slot
function automatic logic [31:0] asmBranch(input opcodeE op, input logic [4:0] rs, rt,
                                          input logic [15:0] offset);
   return {op, rs, rt, offset};
endfunction

function automatic logic [31:0] asmJump(input opcodeE op, input logic [25:0] wordTarget);
   return {op, wordTarget};
endfunction

function automatic logic [31:0] asmNop();
   return NOP_WORD;
endfunction

`endif

// File: verif/coreTb.sv
`timescale 1ns/1ps

module coreTb import mipsPkg::*; ();

   `include "tbAsm.svh"

   logic               CLK;
   logic               arstN;
   logic               bootWe;
   logic [IMEM_AW-1:0] bootAddr;
   logic [31:0]        bootData;
   logic [7:0]         txData;
   logic               txValid;
   logic               txReady;
   logic [7:0]         rxData;
   logic               rxValid;
   logic               rxReady;

   logic [31:0] prog[$];       // program image for the next run
   logic [31:0] expWords[$];
   logic [7:0]  expBytes[$];
   logic [7:0]  gotBytes[$];   // bytes seen on txValid
   logic [7:0]  rxQueue[$];
   logic        randomReady;
   logic        popPending;
   int          budget;        // watchdog limit in cycles, grows per test
   int          cycleCount;

   mipsCore mipsCore_inst (
      .CLK(CLK), .arstN(arstN),
      .bootWe(bootWe), .bootAddr(bootAddr), .bootData(bootData),
      .txData(txData), .txValid(txValid), .txReady(txReady),
      .rxData(rxData), .rxValid(rxValid), .rxReady(rxReady)
   );

   initial begin
      CLK = 1'b0;
      forever #2 CLK = ~CLK;
   end

   // serial partner, driven just after the rising edge
   initial begin
      forever begin
         @(posedge CLK);
         #1;
         if (popPending) begin
            void'(rxQueue.pop_front());   // consumed in the cycle before
            popPending = 1'b0;
         end
         rxValid = (rxQueue.size() > 0);
         rxData  = (rxQueue.size() > 0) ? rxQueue[0] : 8'h00;
         txReady = randomReady ? 1'($urandom % 2) : 1'b1;
      end
   end

   // strobes are sampled mid-cycle
   initial begin
      forever begin
         @(negedge CLK);
         if (txValid) begin
            gotBytes.push_back(txData);
         end
         if (rxReady) begin
            if (rxQueue.size() == 0) begin
               $display("rxReady pulsed while no receive byte was waiting");
               endWithFailure();
            end else begin
               popPending = 1'b1;
            end
         end
      end
   end

   initial begin
      forever begin
         @(posedge CLK);
         cycleCount++;
         if (cycleCount > budget) begin
            $display("watchdog expired after %0d cycles, the core stopped responding",
                     cycleCount);
            endWithFailure();
         end
      end
   end

   task automatic endWithFailure();
      $display("Test failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic compareByte(input string testName, input logic [7:0] expected,
                              input logic [7:0] actual);
      if (actual !== expected) begin
         $display("** Error: %s expected %h actual %h", testName, expected, actual);
         endWithFailure();
      end
   endtask

   task automatic compareWord(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("** Error: %s expected %h actual %h", testName, expected, actual);
         endWithFailure();
      end
   endtask

   task automatic emit(input logic [31:0] word);
      prog.push_back(word);
   endtask

   // $30 points at the serial port, $27 at a scratch word
   task automatic emitPrologue();
      prog.delete();
      emit(asmI(OP_LUI, 5'd30, 5'd0, SERIAL_BASE[31:16]));
      emit(asmI(OP_ADDIU, 5'd27, 5'd0, 16'h0100));
   endtask

   task automatic emitSendByte(input logic [4:0] r);
      emit(asmI(OP_SB, r, 5'd30, {12'h000, SERIAL_TX}));
   endtask

   // no right shift in the subset, so bytes come back through memory msb first
   task automatic emitSendWord(input logic [4:0] r);
      emit(asmI(OP_SW, r, 5'd27, 16'h0000));
      for (int k = 0; k < 4; k++) begin
         emit(asmI(OP_LBU, 5'd28, 5'd27, 16'(k)));
         emitSendByte(5'd28);
      end
   endtask

   task automatic emitConst(input logic [4:0] r, input logic [31:0] value);
      emit(asmI(OP_LUI, r, 5'd0, value[31:16]));
      emit(asmI(OP_ORI, r, r, value[15:0]));
   endtask

   task automatic emitAndExpect(input logic [31:0] word, input logic [4:0] rd,
                                input logic [31:0] expected);
      emit(word);
      emitSendWord(rd);
      expWords.push_back(expected);
   endtask

   task automatic emitHalt();
      emit(asmJump(OP_J, 26'(prog.size())));   // spin here
      emit(asmNop());
   endtask

   task automatic patchBranch(input int at, input opcodeE op, input logic [4:0] rs,
                              input logic [4:0] rt, input int dest);
      prog[at] = asmBranch(op, rs, rt, 16'(dest - at - 1));
   endtask

   // reset, boot load, release, then wait for the expected byte count
   task automatic runProgram(input string testName, input int expCount);
      int resetCycles;
      int waited;
      resetCycles = (prog.size() > 16) ? prog.size() : 16;
      budget += prog.size() * 40 + resetCycles + 16;
      @(posedge CLK);
      #1;
      arstN = 1'b0;
      gotBytes.delete();
      for (int i = 0; i < resetCycles; i++) begin
         bootWe   = (i < prog.size());
         bootAddr = i[IMEM_AW-1:0];
         bootData = (i < prog.size()) ? prog[i] : NOP_WORD;
         @(posedge CLK);
         #1;
      end
      bootWe = 1'b0;
      arstN  = 1'b1;
      waited = 0;
      while (gotBytes.size() < expCount) begin
         if (waited >= prog.size() * 40) begin
            $display("%s: only %0d of %0d bytes were transmitted", testName,
                     gotBytes.size(), expCount);
            endWithFailure();
         end else begin
            @(posedge CLK);
            waited++;
         end
      end
      repeat (16) @(posedge CLK);   // room for stray bytes
      if (gotBytes.size() != expCount) begin
         $display("%s: %0d bytes were transmitted where %0d were expected", testName,
                  gotBytes.size(), expCount);
         endWithFailure();
      end
   endtask

   task automatic checkWords(input string testName);
      for (int i = 0; i < expWords.size(); i++) begin
         compareWord(testName, expWords[i],
                     {gotBytes[4*i], gotBytes[4*i+1], gotBytes[4*i+2], gotBytes[4*i+3]});
      end
   endtask

   task automatic checkBytes(input string testName);
      for (int i = 0; i < expBytes.size(); i++) begin
         compareByte(testName, expBytes[i], gotBytes[i]);
      end
   endtask

   task automatic aluTest();
      logic [31:0] a;
      logic [31:0] b;
      logic [4:0]  sh;
      a  = $urandom & 32'h7fff_ffff;   // positive
      b  = $urandom | 32'h8000_0000;   // negative
      sh = 5'($urandom % 31) + 5'd1;
      emitPrologue();
      expWords.delete();
      emitConst(5'd1, a);
      emitConst(5'd2, b);
      emitAndExpect(asmR(F_ADDU, 5'd3, 5'd1, 5'd2), 5'd3, a + b);
      emitAndExpect(asmR(F_SUBU, 5'd4, 5'd1, 5'd2), 5'd4, a - b);
      emitAndExpect(asmR(F_AND, 5'd5, 5'd1, 5'd2), 5'd5, a & b);
      emitAndExpect(asmR(F_OR, 5'd6, 5'd1, 5'd2), 5'd6, a | b);
      emitAndExpect(asmR(F_XOR, 5'd7, 5'd1, 5'd2), 5'd7, a ^ b);
      emitAndExpect(asmR(F_SLT, 5'd8, 5'd2, 5'd1), 5'd8, 32'd1);   // negative below positive
      emitAndExpect(asmR(F_SLT, 5'd9, 5'd1, 5'd2), 5'd9, 32'd0);
      emitAndExpect(asmSll(5'd10, 5'd1, sh), 5'd10, a << sh);
      emit(asmI(OP_ADDIU, 5'd11, 5'd0, 16'hfffb));
      emit(asmI(OP_ADDIU, 5'd11, 5'd11, 16'h0003));
      emitAndExpect(asmR(F_SUBU, 5'd12, 5'd11, 5'd1), 5'd12, 32'hffff_fffe - a);
      emitHalt();
      runProgram("alu", expWords.size() * 4);
      checkWords("alu");
   endtask

   task automatic memoryTest();
      logic [31:0] w;
      logic [15:0] half;
      logic [7:0]  byteVal;
      logic [7:0]  sb1;
      logic [7:0]  sb3;
      w   = ($urandom & 32'h7f7f_7f7f) | 32'h8000_0080;   // bytes 0 and 3 negative
      sb1 = 8'($urandom);
      sb3 = 8'($urandom);
      emitPrologue();
      expWords.delete();
      emit(asmI(OP_ADDIU, 5'd26, 5'd0, 16'h0200));
      emitConst(5'd1, w);
      emit(asmI(OP_SW, 5'd1, 5'd26, 16'h0000));
      emitAndExpect(asmI(OP_LW, 5'd2, 5'd26, 16'h0000), 5'd2, w);
      for (int k = 0; k < 4; k += 2) begin
         half = w[31 - 8 * k -: 16];
         emitAndExpect(asmI(OP_LH, 5'd2, 5'd26, 16'(k)), 5'd2, {{16{half[15]}}, half});
         emitAndExpect(asmI(OP_LHU, 5'd2, 5'd26, 16'(k)), 5'd2, {16'h0000, half});
      end
      for (int k = 0; k < 4; k++) begin
         byteVal = w[31 - 8 * k -: 8];   // offset 0 is the msb
         emitAndExpect(asmI(OP_LB, 5'd2, 5'd26, 16'(k)), 5'd2, {{24{byteVal[7]}}, byteVal});
         emitAndExpect(asmI(OP_LBU, 5'd2, 5'd26, 16'(k)), 5'd2, {24'h000000, byteVal});
      end
      emit(asmI(OP_ADDIU, 5'd3, 5'd0, {8'h00, sb1}));
      emit(asmI(OP_SB, 5'd3, 5'd26, 16'h0001));
      emit(asmI(OP_ADDIU, 5'd4, 5'd0, {8'h00, sb3}));
      emit(asmI(OP_SB, 5'd4, 5'd26, 16'h0003));
      emitAndExpect(asmI(OP_LW, 5'd5, 5'd26, 16'h0000), 5'd5, {w[31:24], sb1, w[15:8], sb3});
      emitHalt();
      runProgram("memory", expWords.size() * 4);
      checkWords("memory");
   endtask

   task automatic controlFlowTest();
      int brTaken;
      int brBadA;
      int brBadB;
      int brNe;
      int jmpIdx;
      int jalIdx;
      emitPrologue();
      expBytes.delete();
      emit(asmI(OP_ADDIU, 5'd1, 5'd0, 16'd5));
      emit(asmI(OP_ADDIU, 5'd2, 5'd0, 16'd5));
      emit(asmI(OP_ADDIU, 5'd3, 5'd0, 16'd7));
      emit(asmI(OP_ADDIU, 5'd12, 5'd0, 16'h00ee));   // sent only on a wrong path
      for (int m = 0; m < 8; m++) begin
         emit(asmI(OP_ADDIU, 5'(16 + m), 5'd0, 16'(161 + m)));   // markers a1 to a8
      end
      brTaken = prog.size();
      emit(asmNop());
      emitSendByte(5'd16);   // delay slot
      emitSendByte(5'd12);
      patchBranch(brTaken, OP_BEQ, 5'd1, 5'd2, prog.size());
      brBadA = prog.size();
      emit(asmNop());
      emitSendByte(5'd17);
      emitSendByte(5'd18);   // fall through
      brBadB = prog.size();
      emit(asmNop());
      emit(asmNop());
      brNe = prog.size();
      emit(asmNop());
      emitSendByte(5'd19);
      emitSendByte(5'd12);
      patchBranch(brNe, OP_BNE, 5'd1, 5'd3, prog.size());
      jmpIdx = prog.size();
      emit(asmNop());
      emitSendByte(5'd20);
      emitSendByte(5'd12);
      prog[jmpIdx] = asmJump(OP_J, 26'(prog.size()));
      jalIdx = prog.size();
      emit(asmNop());
      emitSendByte(5'd21);
      emitSendByte(5'd23);   // return lands here
      emitHalt();
      prog[jalIdx] = asmJump(OP_JAL, 26'(prog.size()));
      emitSendByte(5'd31);
      emit(asmJr(5'd31));
      emitSendByte(5'd22);
      patchBranch(brBadA, OP_BNE, 5'd1, 5'd2, prog.size());
      patchBranch(brBadB, OP_BEQ, 5'd1, 5'd3, prog.size());
      emitSendByte(5'd12);
      emitHalt();
      for (int m = 0; m < 6; m++) begin
         expBytes.push_back(8'(161 + m));
      end
      expBytes.push_back(8'(jalIdx * 4 + 8));   // link is pc plus 8
      expBytes.push_back(8'hA7);
      expBytes.push_back(8'hA8);
      runProgram("control flow", expBytes.size());
      checkBytes("control flow");
   endtask

   task automatic loadUseTest();
      logic [31:0] v;
      v = $urandom;
      emitPrologue();
      expWords.delete();
      emit(asmI(OP_ADDIU, 5'd26, 5'd0, 16'h0300));
      emitConst(5'd1, v);
      emit(asmI(OP_SW, 5'd1, 5'd26, 16'h0000));
      emit(asmI(OP_LW, 5'd2, 5'd26, 16'h0000));
      emitAndExpect(asmR(F_ADDU, 5'd3, 5'd2, 5'd2), 5'd3, v + v);
      emit(asmI(OP_LBU, 5'd4, 5'd26, 16'h0003));
      emitAndExpect(asmI(OP_ADDIU, 5'd5, 5'd4, 16'h0001), 5'd5, {24'h000000, v[7:0]} + 32'd1);
      emit(asmI(OP_LH, 5'd6, 5'd26, 16'h0000));
      emitAndExpect(asmR(F_SUBU, 5'd7, 5'd0, 5'd6), 5'd7, 32'd0 - {{16{v[31]}}, v[31:16]});
      emitHalt();
      runProgram("load use", expWords.size() * 4);
      checkWords("load use");
   endtask

   task automatic serialTest();
      logic [7:0] b;
      int         poll;
      int         brIdx;
      randomReady = 1'b1;
      emitPrologue();
      expBytes.delete();
      rxQueue.delete();
      for (int i = 0; i < 16; i++) begin
         b = 8'($urandom);
         emit(asmI(OP_ADDIU, 5'd1, 5'd0, {8'h00, b}));
         emitSendByte(5'd1);
         expBytes.push_back(b);
      end
      for (int i = 0; i < 4; i++) begin
         b = 8'($urandom);
         rxQueue.push_back(b);
         expBytes.push_back(b + 8'd1);   // echo adds one
      end
      emit(asmI(OP_ADDIU, 5'd20, 5'd0, 16'd4));
      emit(asmI(OP_ADDIU, 5'd3, 5'd0, 16'd2));   // rxValid bit of status
      poll = prog.size();
      emit(asmI(OP_LW, 5'd2, 5'd30, {12'h000, SERIAL_STATUS}));
      emit(asmR(F_AND, 5'd4, 5'd2, 5'd3));
      brIdx = prog.size();
      emit(asmNop());
      patchBranch(brIdx, OP_BEQ, 5'd4, 5'd0, poll);
      emit(asmNop());
      emit(asmI(OP_LW, 5'd5, 5'd30, {12'h000, SERIAL_RX}));
      emit(asmI(OP_ADDIU, 5'd5, 5'd5, 16'h0001));
      emitSendByte(5'd5);
      emit(asmI(OP_ADDIU, 5'd20, 5'd20, 16'hffff));
      brIdx = prog.size();
      emit(asmNop());
      patchBranch(brIdx, OP_BNE, 5'd20, 5'd0, poll);
      emit(asmNop());
      emitHalt();
      runProgram("serial", expBytes.size());
      checkBytes("serial");
      if (rxQueue.size() != 0) begin
         $display("serial: %0d receive bytes were never consumed", rxQueue.size());
         endWithFailure();
      end
      randomReady = 1'b0;
   endtask

   initial begin
      arstN       = 1'b0;
      bootWe      = 1'b0;
      bootAddr    = '0;
      bootData    = '0;
      txReady     = 1'b1;
      rxData      = 8'h00;
      rxValid     = 1'b0;
      randomReady = 1'b0;
      popPending  = 1'b0;
      budget      = 0;
      cycleCount  = 0;
      void'($urandom(91319));
      aluTest();
      memoryTest();
      controlFlowTest();
      loadUseTest();
      serialTest();
      $display("Test passed");
      $finish;
   end

endmodule
